// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module app_tb -f src.f -o app_sim \
   && ./obj_dir/app_sim 2>&1 | tee sim.log \
   || echo "build or simulation error"
grep -q "^Verification passed$" sim.log 2>/dev/null && echo "run ok" \
   || { echo "run failed"; exit 1; }

// ==== src.f ====
src/app_pkg.sv
src/app_out_buffer.sv
src/app_pacer.sv
src/app_crc32.sv
src/app_lfsr.sv
src/app_ram.sv
src/app_fsm.sv
src/app_top.sv
verification/tb_clock.sv
verification/app_props.sv
verification/app_tb.sv

// ==== src/app_crc32.sv ====
//################################################
// CRC-32 accumulator
// Byte-wise CRC update with selectable result byte
//################################################
module app_crc32 (
   input  logic               clk_i,
   input  logic               rstn,
   input  logic               init_i,
   input  logic               upd_i,
   input  logic [7:0]         data_i,
   input  app_pkg::byte_sel_t sel_i,
   output logic [7:0]         crc_byte_o
);
   import app_pkg::*;

   logic [31:0] crc_q;
   logic [7:0]  raw_byte;

   // MSB-first register fed with the data bits LSB first
   function automatic logic [31:0] crc_step(input logic [7:0] d, input logic [31:0] c);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (d[i] ^ r[31]) begin
            r = {r[30:0], 1'b0} ^ CRC_POLY;
         end else begin
            r = {r[30:0], 1'b0};
         end
      end
      return r;
   endfunction

   function automatic logic [7:0] rev8(input logic [7:0] d);
      logic [7:0] r;
      for (int i = 0; i < 8; i++) begin
         r[i] = d[7-i];
      end
      return r;
   endfunction

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         crc_q <= '1;
      end else if (init_i) begin
         crc_q <= '1;
      end else if (upd_i) begin
         crc_q <= crc_step(data_i, crc_q);
      end
   end

   // Select 0 is the top register byte, which is the low byte of the CRC
   assign raw_byte = crc_q[{~sel_i, 3'b000} +: 8];
   assign crc_byte_o = rev8(~raw_byte);

endmodule

// ==== src/app_fsm.sv ====
//################################################
// Application FSM
// Parses escape, opcode and arguments, runs loopback
// and the IN, OUT, RAM read and readout sequences
//################################################
module app_fsm (
   input  logic                  clk_i,
   input  logic                  rstn,
   input  app_pkg::byte_stream_t buf_i,
   output logic                  pop_o,
   input  logic                  in_ready_i,
   input  logic                  gap_i,
   input  logic                  last_i,
   output logic [7:0]            in_data_o,
   output logic                  in_valid_o,
   output app_pkg::arg_load_t    arg_o,
   output logic                  cnt_load_o,
   output logic                  wait_load_o,
   output logic                  lfsr_load_o,
   output logic                  addr_load_o,
   output logic                  step_o,
   output logic                  lfsr_step_o,
   output logic                  crc_init_o,
   output logic                  crc_upd_o,
   output logic [7:0]            crc_data_o,
   output app_pkg::byte_sel_t    sel_o,
   output logic                  ram_we_o,
   output logic                  ram_re_o,
   output logic                  ram_inc_o,
   input  logic [7:0]            crc_byte_i,
   input  logic [7:0]            lfsr_byte_i,
   input  logic [7:0]            ram_rdata_i
);
   import app_pkg::*;

   app_state_t state_q;
   app_state_t state_d;
   app_state_t run_state;
   app_cmd_t   cmd_q;
   app_cmd_t   cmd_d;
   logic       mem_valid_q;
   logic       mem_valid_d;
   logic       in_valid;
   logic       in_ready;
   logic       arg_stb;

   // Outbound side is closed while a gap runs
   assign in_ready = in_ready_i & ~gap_i;
   assign in_valid_o = in_valid & ~gap_i;

   assign arg_o.stb = arg_stb;
   assign arg_o.idx = (state_q == CMD3) ? 2'd2 : (state_q == CMD2) ? 2'd1 : 2'd0;
   assign arg_o.data = buf_i.data;

   // State entered once the last argument byte is in
   always_comb begin
      case (cmd_q)
         IN_CMD: run_state = IN;
         OUT_CMD: run_state = OUT;
         RAM_READ_CMD: run_state = READ_RAM;
         default: run_state = LOOPBACK;
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q <= RESET;
         cmd_q <= NO_CMD;
         mem_valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         cmd_q <= cmd_d;
         mem_valid_q <= mem_valid_d;
      end
   end

   always_comb begin
      state_d = state_q;
      cmd_d = cmd_q;
      mem_valid_d = mem_valid_q;
      pop_o = 1'b0;
      in_data_o = buf_i.data;
      in_valid = 1'b0;
      arg_stb = 1'b0;
      cnt_load_o = 1'b0;
      wait_load_o = 1'b0;
      lfsr_load_o = 1'b0;
      addr_load_o = 1'b0;
      step_o = 1'b0;
      lfsr_step_o = 1'b0;
      crc_init_o = 1'b0;
      crc_upd_o = 1'b0;
      crc_data_o = buf_i.data;
      sel_o = 2'd0;
      ram_we_o = 1'b0;
      ram_re_o = 1'b0;
      ram_inc_o = 1'b0;

      case (state_q)
         RESET: begin
            if (buf_i.valid) begin
               state_d = LOOPBACK;
            end
         end
         LOOPBACK: begin
            if (buf_i.valid) begin
               if (buf_i.data == ESC_BYTE) begin
                  pop_o = 1'b1;
                  state_d = CMD0;
               end else begin
                  // Echo and store at the same time
                  in_valid = 1'b1;
                  pop_o = in_ready;
                  ram_we_o = in_ready;
                  ram_inc_o = in_ready;
               end
            end
         end
         CMD0: begin
            pop_o = 1'b1;
            if (buf_i.valid) begin
               cmd_d = app_cmd_t'(buf_i.data);
               state_d = CMD1;
            end
         end
         CMD1, CMD2, CMD3: begin
            crc_init_o = (state_q == CMD3);
            case (cmd_q)
               IN_CMD, OUT_CMD, RAM_READ_CMD, ADDR_CMD, LFSR_WRITE_CMD, WAIT_CMD: begin
                  pop_o = 1'b1;
                  if (buf_i.valid) begin
                     arg_stb = 1'b1;
                     cnt_load_o = (cmd_q == IN_CMD) || (cmd_q == OUT_CMD) ||
                                  (cmd_q == RAM_READ_CMD);
                     addr_load_o = (cmd_q == ADDR_CMD);
                     lfsr_load_o = (cmd_q == LFSR_WRITE_CMD);
                     wait_load_o = (cmd_q == WAIT_CMD);
                     // WAIT takes a single argument byte
                     if (state_q == CMD1 && cmd_q != WAIT_CMD) begin
                        state_d = CMD2;
                     end else if (state_q == CMD2) begin
                        state_d = CMD3;
                     end else begin
                        state_d = run_state;
                     end
                  end
               end
               LFSR_READ_CMD: state_d = READ0;
               default: state_d = LOOPBACK;
            endcase
         end
         IN: begin
            in_data_o = lfsr_byte_i;
            crc_data_o = lfsr_byte_i;
            in_valid = 1'b1;
            if (in_ready) begin
               crc_upd_o = 1'b1;
               lfsr_step_o = 1'b1;
               step_o = 1'b1;
               if (last_i) begin
                  state_d = READ0;
               end
            end
         end
         OUT: begin
            pop_o = ~gap_i;
            if (buf_i.valid && !gap_i) begin
               crc_upd_o = 1'b1;
               step_o = 1'b1;
               if (last_i) begin
                  state_d = READ0;
               end
            end
         end
         READ0, READ1, READ2, READ3: begin
            sel_o = state_q[1:0];
            in_data_o = (cmd_q == LFSR_READ_CMD) ? lfsr_byte_i : crc_byte_i;
            in_valid = 1'b1;
            if (in_ready) begin
               state_d = (state_q == READ3) ? LOOPBACK : app_state_t'(state_q + 4'd1);
            end
         end
         READ_RAM: begin
            in_data_o = ram_rdata_i;
            in_valid = mem_valid_q;
            if (!mem_valid_q) begin
               ram_re_o = 1'b1;
               ram_inc_o = 1'b1;
               mem_valid_d = 1'b1;
            end else if (in_ready) begin
               mem_valid_d = 1'b0;
               step_o = 1'b1;
               if (last_i) begin
                  // Address goes back to zero, arg strobe is low here
                  addr_load_o = 1'b1;
                  state_d = LOOPBACK;
               end
            end
         end
         default: state_d = LOOPBACK;
      endcase
   end

endmodule

// ==== src/app_lfsr.sv ====
//################################################
// Pseudo-random byte source
// 24-bit XNOR LFSR, loaded and read one byte at a time
//################################################
module app_lfsr (
   input  logic               clk_i,
   input  logic               rstn,
   input  app_pkg::arg_load_t arg_i,
   input  logic               load_i,
   input  logic               step_i,
   input  app_pkg::byte_sel_t sel_i,
   output logic [7:0]         lfsr_byte_o
);
   import app_pkg::*;

   logic [23:0] lfsr_q;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         lfsr_q <= '0;
      end else if (load_i && arg_i.stb) begin
         lfsr_q <= put_byte(lfsr_q, arg_i);
      end else if (step_i) begin
         lfsr_q <= {lfsr_q[22:0], ~^(lfsr_q & LFSR_TAPS)};
      end
   end

   // Fourth byte of a readout pads with zero
   always_comb begin
      case (sel_i)
         2'd0: lfsr_byte_o = lfsr_q[7:0];
         2'd1: lfsr_byte_o = lfsr_q[15:8];
         2'd2: lfsr_byte_o = lfsr_q[23:16];
         default: lfsr_byte_o = 8'h00;
      endcase
   end

endmodule

// ==== src/app_out_buffer.sv ====
//################################################
// Inbound byte buffer
// One-entry holding register between the out stream
// and the FSM, closed while a pacing gap runs
//################################################
module app_out_buffer (
   input  logic                  clk_i,
   input  logic                  rstn,
   input  logic [7:0]            out_data_i,
   input  logic                  out_valid_i,
   output logic                  out_ready_o,
   input  logic                  gap_i,
   input  logic                  pop_i,
   output app_pkg::byte_stream_t buf_o
);

   logic [7:0] data_q;
   logic       valid_q;

   // Free slot or one being consumed, and no gap pending
   assign out_ready_o = (~valid_q | pop_i) & ~gap_i;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         valid_q <= 1'b0;
      end else if (out_valid_i && out_ready_o) begin
         valid_q <= 1'b1;
      end else if (pop_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_valid_i && out_ready_o) begin
         data_q <= out_data_i;
      end
   end

   assign buf_o.data = data_q;
   assign buf_o.valid = valid_q;

endmodule

// ==== src/app_pacer.sv ====
//################################################
// Stream pacer
// Byte count of the running stream and the idle gap
// that follows each streamed data byte
//################################################
module app_pacer (
   input  logic               clk_i,
   input  logic               rstn,
   input  app_pkg::arg_load_t arg_i,
   input  logic               cnt_load_i,
   input  logic               wait_load_i,
   input  logic               step_i,
   output logic               gap_o,
   output logic               last_o
);
   import app_pkg::*;

   logic [CNT_W-1:0]  cnt_q;
   logic [WAIT_W-1:0] wait_q;
   logic [WAIT_W-1:0] timer_q;

   assign gap_o = |timer_q;
   assign last_o = (cnt_q == '0);

   // Count of remaining bytes, loaded one argument byte at a time
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         cnt_q <= '0;
      end else if (cnt_load_i && arg_i.stb) begin
         cnt_q <= put_byte(cnt_q, arg_i);
      end else if (step_i && !last_o) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         wait_q <= '0;
      end else if (wait_load_i && arg_i.stb) begin
         wait_q <= arg_i.data;
      end
   end

   // Gap timer restarts at W after every data byte
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         timer_q <= '0;
      end else if (gap_o) begin
         timer_q <= timer_q - 1'b1;
      end else if (step_i) begin
         timer_q <= wait_q;
      end
   end

endmodule

// ==== src/app_pkg.sv ====
//################################################
// App package
// Opcodes, FSM states, sizes and stream types shared
// by the USB serial application block
//################################################
package app_pkg;

   localparam logic [7:0] ESC_BYTE = 8'h00;

   localparam int RAM_SIZE = 1024;
   localparam int RAM_AW = 10;
   localparam int MEM_AW = 24;
   localparam int CNT_W = 24;
   localparam int WAIT_W = 8;

   localparam logic [31:0] CRC_POLY = 32'h04C11DB7;
   // Taps at bits 23, 22, 21 and 16
   localparam logic [23:0] LFSR_TAPS = 24'hE1_0000;

   // READ0..READ3 sit on a 4-aligned block so the low bits give the byte index
   typedef enum logic [3:0] {
      RESET    = 4'd0,
      LOOPBACK = 4'd1,
      CMD0     = 4'd2,
      CMD1     = 4'd3,
      CMD2     = 4'd4,
      CMD3     = 4'd5,
      IN       = 4'd6,
      OUT      = 4'd7,
      READ0    = 4'd8,
      READ1    = 4'd9,
      READ2    = 4'd10,
      READ3    = 4'd11,
      READ_RAM = 4'd12
   } app_state_t;

   typedef enum logic [7:0] {
      NO_CMD         = 8'd0,
      IN_CMD         = 8'd1,
      OUT_CMD        = 8'd2,
      ADDR_CMD       = 8'd3,
      WAIT_CMD       = 8'd4,
      LFSR_WRITE_CMD = 8'd5,
      LFSR_READ_CMD  = 8'd6,
      RAM_READ_CMD   = 8'd8
   } app_cmd_t;

   typedef struct packed {
      logic [7:0] data;
      logic       valid;
   } byte_stream_t;

   // One little-endian argument byte headed for a multi-byte register
   typedef struct packed {
      logic       stb;
      logic [1:0] idx;
      logic [7:0] data;
   } arg_load_t;

   typedef logic [1:0] byte_sel_t;

   // Replace the addressed byte of a 24-bit argument register
   function automatic logic [MEM_AW-1:0] put_byte(input logic [MEM_AW-1:0] cur,
                                                  input arg_load_t arg);
      logic [MEM_AW-1:0] res;
      res = cur;
      case (arg.idx)
         2'd0: res[7:0] = arg.data;
         2'd1: res[15:8] = arg.data;
         2'd2: res[23:16] = arg.data;
         default: res = cur;
      endcase
      return res;
   endfunction

endpackage

// ==== src/app_ram.sv ====
//################################################
// Application RAM
// 1024-byte synchronous RAM behind an auto-incrementing
// 24-bit address register
//################################################
module app_ram (
   input  logic               clk_i,
   input  logic               rstn,
   input  app_pkg::arg_load_t arg_i,
   input  logic               addr_load_i,
   input  logic               inc_i,
   input  logic               we_i,
   input  logic               re_i,
   input  logic [7:0]         wdata_i,
   output logic [7:0]         rdata_o
);
   import app_pkg::*;

   logic [MEM_AW-1:0] addr_q;
   logic [7:0]        mem [RAM_SIZE];

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         addr_q <= '0;
      end else if (addr_load_i) begin
         // Load without a strobe clears the address after a RAM read
         if (arg_i.stb) begin
            addr_q <= put_byte(addr_q, arg_i);
         end else begin
            addr_q <= '0;
         end
      end else if (inc_i) begin
         addr_q <= addr_q + 1'b1;
      end
   end

   // Only the low address bits reach the array
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr_q[RAM_AW-1:0]] <= wdata_i;
      end
      if (re_i) begin
         rdata_o <= mem[addr_q[RAM_AW-1:0]];
      end
   end

endmodule

// ==== src/app_top.sv ====
//################################################
// USB serial application block, top level
// Byte loopback with RAM capture plus command driven
// LFSR, CRC and RAM streams
//################################################
module app_top (
   input  logic       clk_i,
   input  logic       rstn,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   output logic       out_ready_o,
   output logic [7:0] in_data_o,
   output logic       in_valid_o,
   input  logic       in_ready_i
);
   import app_pkg::*;

   byte_stream_t rx_buf;
   arg_load_t    arg;
   byte_sel_t    sel;
   logic         pop;
   logic         gap;
   logic         last;
   logic         cnt_load, wait_load, lfsr_load, addr_load;
   logic         step, lfsr_step;
   logic         crc_init, crc_upd;
   logic         ram_we, ram_re, ram_inc;
   logic [7:0]   crc_data;
   logic [7:0]   crc_byte;
   logic [7:0]   lfsr_byte;
   logic [7:0]   ram_rdata;

   app_out_buffer u_out_buffer (
      .clk_i(clk_i), .rstn(rstn),
      .out_data_i(out_data_i), .out_valid_i(out_valid_i), .out_ready_o(out_ready_o),
      .gap_i(gap), .pop_i(pop), .buf_o(rx_buf)
   );

   app_pacer u_pacer (
      .clk_i(clk_i), .rstn(rstn), .arg_i(arg),
      .cnt_load_i(cnt_load), .wait_load_i(wait_load), .step_i(step),
      .gap_o(gap), .last_o(last)
   );

   app_crc32 u_crc32 (
      .clk_i(clk_i), .rstn(rstn),
      .init_i(crc_init), .upd_i(crc_upd), .data_i(crc_data),
      .sel_i(sel), .crc_byte_o(crc_byte)
   );

   app_lfsr u_lfsr (
      .clk_i(clk_i), .rstn(rstn), .arg_i(arg),
      .load_i(lfsr_load), .step_i(lfsr_step),
      .sel_i(sel), .lfsr_byte_o(lfsr_byte)
   );

   app_ram u_ram (
      .clk_i(clk_i), .rstn(rstn), .arg_i(arg),
      .addr_load_i(addr_load), .inc_i(ram_inc), .we_i(ram_we), .re_i(ram_re),
      .wdata_i(rx_buf.data), .rdata_o(ram_rdata)
   );

   app_fsm u_fsm (
      .clk_i(clk_i), .rstn(rstn),
      .buf_i(rx_buf), .pop_o(pop),
      .in_ready_i(in_ready_i), .gap_i(gap), .last_i(last),
      .in_data_o(in_data_o), .in_valid_o(in_valid_o),
      .arg_o(arg),
      .cnt_load_o(cnt_load), .wait_load_o(wait_load),
      .lfsr_load_o(lfsr_load), .addr_load_o(addr_load),
      .step_o(step), .lfsr_step_o(lfsr_step),
      .crc_init_o(crc_init), .crc_upd_o(crc_upd), .crc_data_o(crc_data),
      .sel_o(sel),
      .ram_we_o(ram_we), .ram_re_o(ram_re), .ram_inc_o(ram_inc),
      .crc_byte_i(crc_byte), .lfsr_byte_i(lfsr_byte), .ram_rdata_i(ram_rdata)
   );

endmodule

// ==== verification/app_props.sv ====
//################################################
// Stream handshake properties
// Bound into the application top level
//################################################
module app_props (
   input logic       clk_i,
   input logic       rstn,
   input logic [7:0] in_data_i,
   input logic       in_valid_i,
   input logic       in_ready_i,
   input logic       out_ready_i,
   input logic       gap_i
);

   int fail_cnt = 0;

   // Outbound byte is held until the sink takes it
   in_hold_a : assert property (
      @(posedge clk_i) disable iff (!rstn)
      (in_valid_i && !in_ready_i) |=> (in_valid_i && $stable(in_data_i))
   ) else begin
      $error("in_valid_o dropped or in_data_o changed before the transfer");
      fail_cnt++;
   end

   // Both streams are closed while the gap timer runs
   gap_closed_a : assert property (
      @(posedge clk_i) disable iff (!rstn)
      gap_i |-> (!out_ready_i && !in_valid_i)
   ) else begin
      $error("out_ready_o or in_valid_o high during a gap");
      fail_cnt++;
   end

endmodule

// ==== verification/app_tb.sv ====
//################################################
// Testbench for the USB serial application block
// Loopback, LFSR, IN, OUT, RAM and gap checks
//################################################
module app_tb;
   import app_pkg::*;

   localparam logic [31:0] RNG_SEED = 32'h86eb_9906;
   localparam int RESET_CYCLES = 10;
   localparam int LOOP_LEN = 20;
   localparam int STREAM_CNT = 31;
   localparam int RAM_LEN = 16;
   localparam int GAP_W = 5;
   // All stream and command bytes, each budgeted for back-pressure and the gap
   localparam int TOTAL_BYTES = LOOP_LEN + 3 * (STREAM_CNT + 5) + 2 * RAM_LEN + 48;
   localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 16 * (GAP_W + 1);

   logic        clk_i;
   logic        rstn;
   logic [7:0]  out_data_i;
   logic        out_valid_i;
   logic        out_ready_o;
   logic [7:0]  in_data_o;
   logic        in_valid_o;
   logic        in_ready_i;

   logic [7:0]  exp_q[$];
   logic [7:0]  got_q[$];
   int          time_q[$];
   logic        ready_pat[$];
   int          err_cnt;
   int          check_cnt;
   int          test_cnt;
   int          test_fail_cnt;
   int          mon_cycle;
   int          run_cycle;
   logic [23:0] in_seed;

   tb_clock u_clock (.clk_o(clk_i));

   app_top uut (
      .clk_i(clk_i), .rstn(rstn),
      .out_data_i(out_data_i), .out_valid_i(out_valid_i), .out_ready_o(out_ready_o),
      .in_data_o(in_data_o), .in_valid_o(in_valid_o), .in_ready_i(in_ready_i)
   );

   bind app_top app_props u_props (
      .clk_i(clk_i), .rstn(rstn),
      .in_data_i(in_data_o), .in_valid_i(in_valid_o), .in_ready_i(in_ready_i),
      .out_ready_i(out_ready_o), .gap_i(gap)
   );

   // Standard reflected CRC-32 with final inversion
   function automatic logic [31:0] crc32_ref(input logic [7:0] data[$]);
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      foreach (data[i]) begin
         c = c ^ {24'h0, data[i]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   function automatic logic [23:0] lfsr_next(input logic [23:0] s);
      return {s[22:0], ~(s[23] ^ s[22] ^ s[21] ^ s[16])};
   endfunction

   function automatic logic [7:0] rand_byte(input logic nonzero);
      logic [31:0] r;
      r = nonzero ? $urandom_range(255, 1) : $urandom();
      return r[7:0];
   endfunction

   task automatic check(input string name, input logic [7:0] exp_val,
                        input logic [7:0] got_val);
      check_cnt++;
      if (exp_val !== got_val) begin
         $display("error %s exp=%h got=%h", name, exp_val, got_val);
         err_cnt++;
      end
   endtask

   // CRC goes out least significant byte first
   task automatic push_crc(input logic [7:0] data[$]);
      logic [31:0] c;
      c = crc32_ref(data);
      for (int i = 0; i < 4; i++) begin
         exp_q.push_back(c[7:0]);
         c = c >> 8;
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      logic done;
      out_data_i = b;
      out_valid_i = 1'b1;
      done = 1'b0;
      while (!done) begin
         @(posedge clk_i);
         done = out_ready_o;
         @(negedge clk_i);
      end
      out_valid_i = 1'b0;
   endtask

   task automatic send_cmd(input logic [7:0] op, input int nargs, input logic [23:0] arg);
      logic [23:0] a;
      a = arg;
      send_byte(8'h00);
      send_byte(op);
      for (int i = 0; i < nargs; i++) begin
         send_byte(a[7:0]);
         a = a >> 8;
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
      repeat (8) @(negedge clk_i);
      if (got_q.size() != 0) begin
         $display("%0d unexpected bytes left on in_data_o", got_q.size());
         err_cnt++;
         got_q.delete();
      end
   endtask

   task automatic run_in_stream(input logic [23:0] seed, input int cnt);
      logic [23:0] s;
      logic [7:0]  data[$];
      s = seed;
      for (int i = 0; i <= cnt; i++) begin
         data.push_back(s[7:0]);
         exp_q.push_back(s[7:0]);
         s = lfsr_next(s);
      end
      push_crc(data);
      send_cmd(LFSR_WRITE_CMD, 3, seed);
      send_cmd(IN_CMD, 3, 24'(cnt));
      wait_drain();
   endtask

   // Idle cycles after each data byte, the last one included
   task automatic check_gaps(input int n);
      int idle;
      if (time_q.size() < n + 1) begin
         $display("gap check saw only %0d transfers, needs %0d", time_q.size(), n + 1);
         err_cnt++;
      end else begin
         for (int i = 0; i < n; i++) begin
            idle = time_q[i + 1] - time_q[i] - 1;
            if (idle < GAP_W) begin
               $display("only %0d idle cycles after data byte %0d, wait is %0d",
                        idle, i, GAP_W);
               err_cnt++;
            end
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      test_cnt++;
      if (err_cnt == err_before) begin
         $display("test %s: ok", name);
      end else begin
         test_fail_cnt++;
         $display("test %s: %0d errors", name, err_cnt - err_before);
      end
   endtask

   // Sink back-pressure from a fixed random pattern
   initial begin
      int k;
      in_ready_i = 1'b0;
      k = 0;
      forever begin
         @(negedge clk_i);
         in_ready_i = rstn & ready_pat[k];
         k = (k + 1) % 256;
      end
   end

   initial begin
      mon_cycle = 0;
      forever begin
         @(posedge clk_i);
         mon_cycle++;
         if (rstn && in_valid_o && in_ready_i) begin
            got_q.push_back(in_data_o);
            time_q.push_back(mon_cycle);
         end
      end
   end

   initial begin
      logic [7:0] exp_b;
      logic [7:0] got_b;
      forever begin
         @(negedge clk_i);
         while (exp_q.size() > 0 && got_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            got_b = got_q.pop_front();
            check("in_data_o", exp_b, got_b);
         end
      end
   end

   initial begin
      run_cycle = 0;
      while (run_cycle < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         run_cycle++;
      end
      $display("timeout after %0d cycles, the DUT stopped responding", run_cycle);
      $display("Verification failed");
      $finish;
   end

   initial begin
      logic [7:0]  data[$];
      logic [7:0]  b;
      logic [23:0] lfsr_seed;
      logic [31:0] r;
      int          err_before;
      int          total_err;
      void'($urandom(RNG_SEED));
      for (int i = 0; i < 256; i++) begin
         r = $urandom_range(3, 0);
         ready_pat.push_back(r != 0);
      end
      out_data_i = 8'h00;
      out_valid_i = 1'b0;
      rstn = 1'b0;
      err_cnt = 0;
      check_cnt = 0;
      test_cnt = 0;
      test_fail_cnt = 0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rstn = 1'b1;

      err_before = err_cnt;
      for (int i = 0; i < LOOP_LEN; i++) begin
         b = rand_byte(1'b1);
         exp_q.push_back(b);
         send_byte(b);
      end
      wait_drain();
      finish_test("loopback", err_before);

      err_before = err_cnt;
      r = $urandom();
      lfsr_seed = r[23:0];
      exp_q.push_back(lfsr_seed[7:0]);
      exp_q.push_back(lfsr_seed[15:8]);
      exp_q.push_back(lfsr_seed[23:16]);
      exp_q.push_back(8'h00);
      send_cmd(LFSR_WRITE_CMD, 3, lfsr_seed);
      send_cmd(LFSR_READ_CMD, 0, 24'h0);
      wait_drain();
      finish_test("lfsr", err_before);

      err_before = err_cnt;
      r = $urandom();
      in_seed = r[23:0];
      run_in_stream(in_seed, STREAM_CNT);
      finish_test("in_stream", err_before);

      err_before = err_cnt;
      for (int i = 0; i <= STREAM_CNT; i++) begin
         data.push_back(rand_byte(1'b0));
      end
      push_crc(data);
      send_cmd(OUT_CMD, 3, 24'(STREAM_CNT));
      foreach (data[i]) begin
         send_byte(data[i]);
      end
      wait_drain();
      finish_test("out_stream", err_before);

      // Loopback bytes land in RAM from address zero
      err_before = err_cnt;
      data.delete();
      send_cmd(ADDR_CMD, 3, 24'h0);
      for (int i = 0; i < RAM_LEN; i++) begin
         b = rand_byte(1'b1);
         data.push_back(b);
         exp_q.push_back(b);
         send_byte(b);
      end
      wait_drain();
      foreach (data[i]) begin
         exp_q.push_back(data[i]);
      end
      send_cmd(ADDR_CMD, 3, 24'h0);
      send_cmd(RAM_READ_CMD, 3, 24'(RAM_LEN - 1));
      wait_drain();
      finish_test("ram", err_before);

      err_before = err_cnt;
      send_cmd(WAIT_CMD, 1, 24'(GAP_W));
      time_q.delete();
      run_in_stream(in_seed, STREAM_CNT);
      check_gaps(STREAM_CNT + 1);
      finish_test("gap", err_before);

      total_err = err_cnt + uut.u_props.fail_cnt;
      $display("tests=%0d failed=%0d checks=%0d errors=%0d assertion_errors=%0d",
               test_cnt, test_fail_cnt, check_cnt, err_cnt, uut.u_props.fail_cnt);
      if (total_err == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== verification/tb_clock.sv ====
//################################################
// Testbench clock source
// Free-running clock with an 8 time unit period
//################################################
module tb_clock (
   output logic clk_o
);

   localparam int HALF_PERIOD = 4;

   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD) clk_o = ~clk_o;
      end
   end

endmodule
